/* Bender.yml */
package:
  name: core_backend

export_include_dirs:
  - hw

sources:
  - files:
      - hw/isa_pkg.sv
      - hw/pipe_pkg.sv
      - hw/fifo_v3.sv
      - hw/multi_queue.sv
      - hw/issue_decode.sv
      - hw/alu_execute.sv
      - hw/reg_result.sv
      - hw/core_backend_top.sv
  - target: test
    files:
      - tb/core_backend_properties.sv
      - tb/core_backend_tb.sv

/* filelist.f */
+incdir+hw
hw/isa_pkg.sv
hw/pipe_pkg.sv
hw/fifo_v3.sv
hw/multi_queue.sv
hw/issue_decode.sv
hw/alu_execute.sv
hw/reg_result.sv
hw/core_backend_top.sv
tb/core_backend_properties.sv
tb/core_backend_tb.sv

/* hw/alu_execute.sv */
`timescale 1ns/1ns
`include "core_cfg.svh"

module alu_execute
	import isa_pkg::*;
	import pipe_pkg::*;
(
	input  logic                                clk,
	input  logic                                rst_n,
	input  logic                                flush_i,
	input  dec_op_t [`ISSUE_WIDTH-1:0]          op_i,
	input  xlen_t [2*`ISSUE_WIDTH-1:0]          rd_data_i,
	output reg_idx_t [2*`ISSUE_WIDTH-1:0]       rs_idx_o,
	output logic [`ISSUE_WIDTH-1:0]             wr_en_o,
	output reg_idx_t [`ISSUE_WIDTH-1:0]         wr_rd_o,
	output xlen_t [`ISSUE_WIDTH-1:0]            wr_data_o
);

	function automatic xlen_t alu(input dec_op_t op, input xlen_t a, input xlen_t b);
		case (op.opcode)
			OP_ADD:  return a + b;
			OP_SUB:  return a - b;
			OP_AND:  return a & b;
			OP_XOR:  return a ^ b;
			OP_ADDI: return a + op.imm;
			OP_LUI:  return op.imm;
			default: return '0;
		endcase
	endfunction

	xlen_t [2*`ISSUE_WIDTH-1:0] opnd;
	xlen_t [`ISSUE_WIDTH-1:0]   result;

	// read ports: even = rs1, odd = rs2
	for (genvar i = 0; i < `ISSUE_WIDTH; i++) begin : g_lane
		assign rs_idx_o[2*i]     = op_i[i].rs1;
		assign rs_idx_o[2*i+1]   = op_i[i].rs2;
		assign result[i] = alu(op_i[i], opnd[2*i], opnd[2*i+1]);
	end

	// pending pair is not in the regfile yet, bypass it
	always_comb begin
		for (int p = 0; p < 2*`ISSUE_WIDTH; p++) begin
			opnd[p] = rd_data_i[p];
			for (int l = 0; l < `ISSUE_WIDTH; l++) begin
				if (wr_en_o[l] && wr_rd_o[l] == rs_idx_o[p])
					opnd[p] = wr_data_o[l];  // later lane overrides
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_en_o <= '0;
		end else if (flush_i) begin
			wr_en_o <= '0;
		end else begin
			for (int l = 0; l < `ISSUE_WIDTH; l++)
				wr_en_o[l] <= op_i[l].valid & op_i[l].wr_rd;
		end
	end

	always_ff @(posedge clk) begin
		for (int l = 0; l < `ISSUE_WIDTH; l++) begin
			wr_rd_o[l]   <= op_i[l].rd;
			wr_data_o[l] <= result[l];
		end
	end

endmodule

/* hw/core_backend_top.sv */
`timescale 1ns/1ns
`include "core_cfg.svh"

module core_backend_top
	import isa_pkg::*;
	import pipe_pkg::*;
(
	input  logic                                   clk,
	input  logic                                   rst_n,
	input  logic                                   flush_i,
	input  fetch_entry_t [`CORE_CHANNEL-1:0]       push_data_i,
	input  logic [$clog2(`CORE_CHANNEL+1)-1:0]     push_num_i,
	input  logic [$clog2(`CORE_CHANNEL)-1:0]       push_offset_i,
	output logic [$clog2(`ISSUE_WIDTH+1)-1:0]      credit_o,
	output logic [`ISSUE_WIDTH-1:0]                retire_valid_o,
	output reg_idx_t [`ISSUE_WIDTH-1:0]            retire_rd_o,
	output xlen_t [`ISSUE_WIDTH-1:0]               retire_data_o
);

	fetch_entry_t [`CORE_CHANNEL-1:0]          q_data;
	logic [`CORE_CHANNEL-1:0]                  q_valid;
	logic [$clog2(`ISSUE_WIDTH+1)-1:0]         pop_num;
	logic [$clog2(`CORE_CHANNEL+1)-1:0]        q_pop_num;
	dec_op_t [`ISSUE_WIDTH-1:0]                dec_op;
	reg_idx_t [2*`ISSUE_WIDTH-1:0]             rs_idx;
	xlen_t [2*`ISSUE_WIDTH-1:0]                rs_data;
	logic [`ISSUE_WIDTH-1:0]                   wr_en;
	reg_idx_t [`ISSUE_WIDTH-1:0]               wr_rd;
	xlen_t [`ISSUE_WIDTH-1:0]                  wr_data;

	assign q_pop_num = $bits(q_pop_num)'(pop_num);
	assign credit_o  = pop_num;  // one credit back per popped entry

	multi_queue #(
		.DEPTH   (`CORE_DEPTH),
		.CHANNEL (`CORE_CHANNEL),
		.dtype   (fetch_entry_t)
	) u_ibuf (
		.clk           (clk),
		.rst_n         (rst_n),
		.flush_i       (flush_i),
		.data_push_i   (push_data_i),
		.push_num_i    (push_num_i),
		.push_offset_i (push_offset_i),
		.pop_num_i     (q_pop_num),
		.data_pop_o    (q_data),
		.pop_valid_o   (q_valid)
	);

	// decode sees only the oldest pair
	issue_decode u_decode (
		.clk           (clk),
		.rst_n         (rst_n),
		.flush_i       (flush_i),
		.instr_i       (q_data[`ISSUE_WIDTH-1:0]),
		.instr_valid_i (q_valid[`ISSUE_WIDTH-1:0]),
		.pop_num_o     (pop_num),
		.op_o          (dec_op)
	);

	alu_execute u_execute (
		.clk       (clk),
		.rst_n     (rst_n),
		.flush_i   (flush_i),
		.op_i      (dec_op),
		.rd_data_i (rs_data),
		.rs_idx_o  (rs_idx),
		.wr_en_o   (wr_en),
		.wr_rd_o   (wr_rd),
		.wr_data_o (wr_data)
	);

	reg_result u_result (
		.clk            (clk),
		.rst_n          (rst_n),
		.wr_en_i        (wr_en),
		.wr_rd_i        (wr_rd),
		.wr_data_i      (wr_data),
		.rs_idx_i       (rs_idx),
		.rd_data_o      (rs_data),
		.retire_valid_o (retire_valid_o),
		.retire_rd_o    (retire_rd_o),
		.retire_data_o  (retire_data_o)
	);

endmodule

/* hw/core_cfg.svh */
`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

// instruction buffer geometry
`define CORE_CHANNEL 4
`define CORE_DEPTH   4   // entries per lane

// register file and datapath
`define CORE_NREG    16
`define CORE_XLEN    16

// max instructions popped and issued per cycle
`define ISSUE_WIDTH  2

`endif

/* hw/fifo_v3.sv */
`timescale 1ns/1ns

module fifo_v3 #(
	parameter int unsigned DEPTH = 4,
	parameter type dtype = logic [15:0]
) (
	input  logic clk,
	input  logic rst_n,
	input  logic flush_i,
	input  logic push_i,
	input  logic pop_i,
	input  dtype data_i,
	output dtype data_o,
	output logic full_o,
	output logic empty_o
);

	localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

	typedef logic [PTR_W-1:0]            ptr_t;
	typedef logic [$clog2(DEPTH+1)-1:0]  cnt_t;

	dtype mem_q [DEPTH];
	ptr_t rd_ptr_q;
	ptr_t wr_ptr_q;
	cnt_t count_q;
	logic do_push;
	logic do_pop;

	assign full_o  = (count_q == cnt_t'(DEPTH));
	assign empty_o = (count_q == '0);

	// overflow and underflow requests are dropped
	assign do_push = push_i & ~full_o;
	assign do_pop  = pop_i & ~empty_o;

	assign data_o = mem_q[rd_ptr_q];  // head, only meaningful when not empty

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rd_ptr_q <= '0;
			wr_ptr_q <= '0;
			count_q  <= '0;
		end else if (flush_i) begin
			rd_ptr_q <= '0;
			wr_ptr_q <= '0;
			count_q  <= '0;
		end else begin
			if (do_push)
				wr_ptr_q <= (wr_ptr_q == ptr_t'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
			if (do_pop)
				rd_ptr_q <= (rd_ptr_q == ptr_t'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
			count_q <= count_q + cnt_t'(do_push) - cnt_t'(do_pop);
		end
	end

	always_ff @(posedge clk) begin
		if (do_push)
			mem_q[wr_ptr_q] <= data_i;
	end

endmodule

/* hw/isa_pkg.sv */
`include "core_cfg.svh"

package isa_pkg;

	typedef logic [$clog2(`CORE_NREG)-1:0] reg_idx_t;
	typedef logic [`CORE_XLEN-1:0]         xlen_t;

	// code 0 and anything not listed is a no-op
	typedef enum logic [3:0] {
		OP_ADD  = 4'h1,  // rd = rs1 + rs2
		OP_SUB  = 4'h2,  // rd = rs1 - rs2
		OP_AND  = 4'h3,  // rd = rs1 & rs2
		OP_XOR  = 4'h4,  // rd = rs1 ^ rs2
		OP_ADDI = 4'h5,  // rd = rs1 + zext(imm)
		OP_LUI  = 4'h6   // rd = imm << 12
	} opcode_e;

	// 16-bit instruction word, msb first
	typedef struct packed {
		opcode_e  opcode;
		reg_idx_t rd;
		reg_idx_t rs1;
		reg_idx_t rs2;   // also the 4-bit immediate
	} instr_t;

endpackage

/* hw/issue_decode.sv */
`timescale 1ns/1ns
`include "core_cfg.svh"

module issue_decode
	import isa_pkg::*;
	import pipe_pkg::*;
(
	input  logic                                clk,
	input  logic                                rst_n,
	input  logic                                flush_i,
	input  fetch_entry_t [`ISSUE_WIDTH-1:0]     instr_i,
	input  logic [`ISSUE_WIDTH-1:0]             instr_valid_i,
	output logic [$clog2(`ISSUE_WIDTH+1)-1:0]   pop_num_o,
	output dec_op_t [`ISSUE_WIDTH-1:0]          op_o
);

	function automatic dec_op_t decode_instr(input fetch_entry_t ins);
		dec_op_t op;
		op.valid  = 1'b0;  // filled in from the issue regs
		op.opcode = ins.opcode;
		op.rd     = ins.rd;
		op.rs1    = ins.rs1;
		op.rs2    = ins.rs2;
		op.wr_rd  = ins.opcode inside {OP_ADD, OP_SUB, OP_AND, OP_XOR, OP_ADDI, OP_LUI};
		case (ins.opcode)
			OP_ADDI: op.imm = xlen_t'(ins.rs2);
			OP_LUI:  op.imm = xlen_t'(ins.rs2) << 12;
			default: op.imm = '0;
		endcase
		return op;
	endfunction

	dec_op_t [`ISSUE_WIDTH-1:0] dec;
	dec_op_t [`ISSUE_WIDTH-1:0] op_q;
	logic [`ISSUE_WIDTH-1:0]    issue;
	logic [`ISSUE_WIDTH-1:0]    vld_q;
	logic                       rs1_hit;
	logic                       rs2_hit;

	for (genvar i = 0; i < `ISSUE_WIDTH; i++) begin : g_dec
		assign dec[i] = decode_instr(instr_i[i]);
	end

	// lane 1 may not read what lane 0 writes, those go in separate pairs
	assign rs1_hit = (instr_i[1].opcode inside {OP_ADD, OP_SUB, OP_AND, OP_XOR, OP_ADDI})
		&& (instr_i[1].rs1 == instr_i[0].rd);
	assign rs2_hit = (instr_i[1].opcode inside {OP_ADD, OP_SUB, OP_AND, OP_XOR})
		&& (instr_i[1].rs2 == instr_i[0].rd);

	assign issue[0] = instr_valid_i[0];
	assign issue[1] = issue[0] & instr_valid_i[1] & ~(dec[0].wr_rd & (rs1_hit | rs2_hit));

	assign pop_num_o = $bits(pop_num_o)'($countones(issue));

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			vld_q <= '0;
		end else if (flush_i) begin
			vld_q <= '0;
		end else begin
			vld_q <= issue;
		end
	end

	always_ff @(posedge clk) begin
		op_q <= dec;
	end

	always_comb begin
		op_o = op_q;
		for (int i = 0; i < `ISSUE_WIDTH; i++) begin
			op_o[i].valid = vld_q[i];
		end
	end

endmodule

/* hw/multi_queue.sv */
`timescale 1ns/1ns

module multi_queue #(
	parameter int unsigned DEPTH   = 4,  // per channel
	parameter int unsigned CHANNEL = 4,  // power of two
	parameter type dtype = logic [15:0]
) (
	input  logic clk,
	input  logic rst_n,
	input  logic flush_i,

	input  dtype [CHANNEL-1:0]             data_push_i,
	input  logic [$clog2(CHANNEL+1)-1:0]   push_num_i,
	input  logic [$clog2(CHANNEL)-1:0]     push_offset_i,

	input  logic [$clog2(CHANNEL+1)-1:0]   pop_num_i,
	output dtype [CHANNEL-1:0]             data_pop_o,
	output logic [CHANNEL-1:0]             pop_valid_o
);

	typedef logic [$clog2(CHANNEL)-1:0]   lane_t;
	typedef logic [$clog2(CHANNEL+1)-1:0] cnt_t;

	lane_t rd_ptr_q;   // channel holding the oldest entry
	lane_t wr_ptr_q;   // channel taking the next pushed entry

	dtype [CHANNEL-1:0] fifo_in;
	dtype [CHANNEL-1:0] fifo_out;
	logic [CHANNEL-1:0] fifo_push;
	logic [CHANNEL-1:0] fifo_pop;
	logic [CHANNEL-1:0] fifo_empty;

	for (genvar c = 0; c < CHANNEL; c++) begin : g_chan
		lane_t wr_dist;    // position of this channel in the push packet
		lane_t rd_dist;    // position of this channel in pop order
		lane_t src_lane;   // input lane feeding this channel
		lane_t head_chan;  // channel holding the c-th oldest entry

		assign wr_dist   = lane_t'(c) - wr_ptr_q;
		assign rd_dist   = lane_t'(c) - rd_ptr_q;
		assign src_lane  = push_offset_i + wr_dist;
		assign head_chan = rd_ptr_q + lane_t'(c);

		assign fifo_in[c]   = data_push_i[src_lane];
		assign fifo_push[c] = (cnt_t'(wr_dist) < push_num_i);
		assign fifo_pop[c]  = (cnt_t'(rd_dist) < pop_num_i);

		// back into program order
		assign data_pop_o[c]  = fifo_out[head_chan];
		assign pop_valid_o[c] = ~fifo_empty[head_chan];

		fifo_v3 #(
			.DEPTH (DEPTH),
			.dtype (dtype)
		) u_fifo (
			.clk     (clk),
			.rst_n   (rst_n),
			.flush_i (flush_i),
			.push_i  (fifo_push[c]),
			.pop_i   (fifo_pop[c]),
			.data_i  (fifo_in[c]),
			.data_o  (fifo_out[c]),
			.full_o  (),  // credits keep every lane below full
			.empty_o (fifo_empty[c])
		);
	end

	// round robin, both pointers wrap at CHANNEL
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rd_ptr_q <= '0;
			wr_ptr_q <= '0;
		end else if (flush_i) begin
			rd_ptr_q <= '0;
			wr_ptr_q <= '0;
		end else begin
			rd_ptr_q <= rd_ptr_q + lane_t'(pop_num_i);
			wr_ptr_q <= wr_ptr_q + lane_t'(push_num_i);
		end
	end

endmodule

/* hw/pipe_pkg.sv */
package pipe_pkg;

	import isa_pkg::*;

	// one buffer slot holds one raw instruction
	typedef instr_t fetch_entry_t;

	// decoded operation, imm already expanded to full width
	typedef struct packed {
		logic     valid;
		opcode_e  opcode;
		reg_idx_t rd;
		reg_idx_t rs1;
		reg_idx_t rs2;
		xlen_t    imm;
		logic     wr_rd;   // op produces a register result
	} dec_op_t;

endpackage

/* hw/reg_result.sv */
`timescale 1ns/1ns
`include "core_cfg.svh"

module reg_result
	import isa_pkg::*;
(
	input  logic                                clk,
	input  logic                                rst_n,
	input  logic [`ISSUE_WIDTH-1:0]             wr_en_i,
	input  reg_idx_t [`ISSUE_WIDTH-1:0]         wr_rd_i,
	input  xlen_t [`ISSUE_WIDTH-1:0]            wr_data_i,
	input  reg_idx_t [2*`ISSUE_WIDTH-1:0]       rs_idx_i,
	output xlen_t [2*`ISSUE_WIDTH-1:0]          rd_data_o,
	output logic [`ISSUE_WIDTH-1:0]             retire_valid_o,
	output reg_idx_t [`ISSUE_WIDTH-1:0]         retire_rd_o,
	output xlen_t [`ISSUE_WIDTH-1:0]            retire_data_o
);

	xlen_t rf_q [`CORE_NREG];

	// lanes written in order so lane 1 wins on the same rd
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int r = 0; r < `CORE_NREG; r++)
				rf_q[r] <= '0;
		end else begin
			for (int l = 0; l < `ISSUE_WIDTH; l++) begin
				if (wr_en_i[l])
					rf_q[wr_rd_i[l]] <= wr_data_i[l];
			end
		end
	end

	for (genvar p = 0; p < 2*`ISSUE_WIDTH; p++) begin : g_rd
		assign rd_data_o[p] = rf_q[rs_idx_i[p]];
	end

	// pack the pending writes toward lane 0, keeping order
	always_comb begin
		int unsigned slot;
		slot = 0;
		retire_valid_o = '0;
		retire_rd_o    = '0;
		retire_data_o  = '0;
		for (int l = 0; l < `ISSUE_WIDTH; l++) begin
			if (wr_en_i[l]) begin
				retire_valid_o[slot] = 1'b1;
				retire_rd_o[slot]    = wr_rd_i[l];
				retire_data_o[slot]  = wr_data_i[l];
				slot++;
			end
		end
	end

endmodule

/* tb/core_backend_properties.sv */
`timescale 1ns/1ns
`include "core_cfg.svh"

module core_backend_properties (
	input logic                                clk,
	input logic                                rst_n,
	input logic                                flush_i,
	input logic [$clog2(`ISSUE_WIDTH+1)-1:0]   credit_o,
	input logic [`ISSUE_WIDTH-1:0]             retire_valid_o
);

	int fail_count = 0;  // failed assertions so far

	// at most one pair leaves the buffer per cycle
	a_credit_max: assert property (@(posedge clk) disable iff (!rst_n)
		credit_o <= `ISSUE_WIDTH)
		else begin
			$error("credit_o above issue width: %0d", credit_o);
			fail_count++;
		end

	a_retire_packed: assert property (@(posedge clk) disable iff (!rst_n)
		retire_valid_o[1] |-> retire_valid_o[0])  // lanes fill from 0
		else begin
			$error("retire lane 1 valid without lane 0");
			fail_count++;
		end

	// execute valid bits are gone one edge after flush
	a_flush_quiet: assert property (@(posedge clk) disable iff (!rst_n)
		flush_i |=> (retire_valid_o == '0))
		else begin
			$error("retirement in the cycle after a flush");
			fail_count++;
		end

endmodule

bind core_backend_top core_backend_properties u_props (
	.clk            (clk),
	.rst_n          (rst_n),
	.flush_i        (flush_i),
	.credit_o       (credit_o),
	.retire_valid_o (retire_valid_o)
);

/* tb/core_backend_tb.sv */
`timescale 1ns/1ns
`include "core_cfg.svh"

module core_backend_tb;

	localparam DATA_FILE = "tb/core_backend_testdata.txt";
	localparam logic [31:0] LFSR_SEED = 32'hb9dfcd9b;
	localparam int TIMEOUT_MARGIN  = 100;
	localparam int CYCLES_PER_ITEM = 20;
	localparam int CAPACITY = `CORE_CHANNEL * `CORE_DEPTH;
	localparam int NUM_W    = $clog2(`CORE_CHANNEL+1);
	localparam int OFF_W    = $clog2(`CORE_CHANNEL);
	localparam int KIND_PUSH  = 0;
	localparam int KIND_FLUSH = 1;

	logic                                  clk;
	logic                                  rst_n;
	logic                                  flush_i;
	logic [`CORE_CHANNEL-1:0][15:0]        push_data;
	logic [NUM_W-1:0]                      push_num;
	logic [OFF_W-1:0]                      push_offset;
	logic [$clog2(`ISSUE_WIDTH+1)-1:0]     credit;
	logic [`ISSUE_WIDTH-1:0]               retire_valid;
	logic [`ISSUE_WIDTH-1:0][3:0]          retire_rd;
	logic [`ISSUE_WIDTH-1:0][15:0]         retire_data;

	int cmd_kind[$];
	int cmd_offset[$];
	int cmd_count[$];
	logic [63:0] cmd_data[$];   // {lane3, lane2, lane1, lane0}
	logic [3:0]  exp_rd[$];
	logic [15:0] exp_data[$];

	int errors = 0;
	int n_packets = 0;
	int n_checked = 0;
	int cycles = 0;
	int timeout_limit = 0;
	int credits;
	int last_credit;   // credit_o seen this cycle, returned at the next edge
	int credit_sum;
	int pushed;
	int discarded;     // entries dropped by flush before they were popped
	logic [31:0] lfsr;

	core_backend_top dut (
		.clk            (clk),
		.rst_n          (rst_n),
		.flush_i        (flush_i),
		.push_data_i    (push_data),
		.push_num_i     (push_num),
		.push_offset_i  (push_offset),
		.credit_o       (credit),
		.retire_valid_o (retire_valid),
		.retire_rd_o    (retire_rd),
		.retire_data_o  (retire_data)
	);

	always #50 clk = ~clk;

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (expected !== actual) begin
			errors++;
			$display("Fail %s: expected %h, got %h", name, expected, actual);
		end
	endtask

	task automatic read_testdata();
		int fd;
		int code;
		int off;
		int cnt;
		logic [63:0] tag;
		logic [8*256-1:0] rest;
		logic [15:0] w0, w1, w2, w3;
		logic [15:0] rd;
		logic [15:0] val;
		fd = $fopen(DATA_FILE, "r");
		if (fd == 0) begin
			errors++;
			$display("Could not open the stimulus file %s", DATA_FILE);
			return;
		end
		while ($fscanf(fd, "%s", tag) == 1) begin
			if (tag == "P") begin
				code = $fscanf(fd, "%h %h %h %h %h %h", off, cnt, w0, w1, w2, w3);
				if (code != 6) begin
					errors++;
					$display("Packet line with missing fields in %s", DATA_FILE);
				end
				cmd_kind.push_back(KIND_PUSH);
				cmd_offset.push_back(off);
				cmd_count.push_back(cnt);
				cmd_data.push_back({w3, w2, w1, w0});
				n_packets++;
			end else if (tag == "F") begin
				cmd_kind.push_back(KIND_FLUSH);
				cmd_offset.push_back(0);
				cmd_count.push_back(0);
				cmd_data.push_back('0);
			end else if (tag == "E") begin
				code = $fscanf(fd, "%h %h", rd, val);
				if (code != 2) begin
					errors++;
					$display("Expected-value line with missing fields in %s", DATA_FILE);
				end
				exp_rd.push_back(rd[3:0]);
				exp_data.push_back(val);
			end else begin
				code = $fgets(rest, fd);  // comment line
			end
		end
		$fclose(fd);
	endtask

	// move to the next falling edge and collect the credit of the edge just passed
	task automatic next_cycle();
		@(negedge clk);
		credits += last_credit;
		credit_sum += last_credit;
		last_credit = credit;
	endtask

	task automatic idle_gaps();
		lfsr = lfsr_step(lfsr);
		while (lfsr[0]) begin
			next_cycle();
			lfsr = lfsr_step(lfsr);
		end
	endtask

	// buffer empty and the last pair retired
	task automatic drain_pipeline();
		while (credits < CAPACITY)
			next_cycle();
		repeat (3) next_cycle();
	endtask

	task automatic send_packet(input int idx);
		while (credits < cmd_count[idx])
			next_cycle();
		push_data   = cmd_data[idx];
		push_num    = NUM_W'(cmd_count[idx]);
		push_offset = OFF_W'(cmd_offset[idx]);
		credits -= cmd_count[idx];
		pushed  += cmd_count[idx];
		next_cycle();
		push_num = '0;
	endtask

	task automatic flush_all();
		flush_i = 1'b1;
		next_cycle();
		flush_i = 1'b0;
		discarded += CAPACITY - credits;
		credits = CAPACITY;  // sender starts over with full capacity
	endtask

	// retire outputs are stable at the falling edge
	always @(negedge clk) begin
		if (rst_n) begin
			for (int l = 0; l < `ISSUE_WIDTH; l++) begin
				if (retire_valid[l] && exp_rd.size() == 0) begin
					errors++;
					$display("Retirement of r%0d on lane %0d with no expected entry left",
						retire_rd[l], l);
				end else if (retire_valid[l]) begin
					check_value($sformatf("retire_rd_o[%0d]", l), exp_rd[0], retire_rd[l]);
					check_value($sformatf("retire_data_o[%0d]", l), exp_data[0],
						retire_data[l]);
					void'(exp_rd.pop_front());
					void'(exp_data.pop_front());
					n_checked++;
				end
			end
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (timeout_limit > 0 && cycles >= timeout_limit) begin
			$display("Timeout after %0d cycles, %0d expected retirements still missing",
				cycles, exp_rd.size());
			$display("Simulation finished: FAIL");
			$finish;
		end
	end

	initial begin
		int i;
		int assert_fails;
		clk         = 1'b0;
		rst_n       = 1'b0;
		flush_i     = 1'b0;
		push_data   = '0;
		push_num    = '0;
		push_offset = '0;
		credits     = CAPACITY;
		last_credit = 0;
		credit_sum  = 0;
		pushed      = 0;
		discarded   = 0;
		lfsr        = LFSR_SEED;
		read_testdata();
		timeout_limit = CYCLES_PER_ITEM * (n_packets + exp_rd.size()) + TIMEOUT_MARGIN;
		repeat (8) @(posedge clk);
		next_cycle();
		rst_n = 1'b1;

		for (i = 0; i < cmd_kind.size(); i++) begin
			if (cmd_kind[i] == KIND_FLUSH) begin
				flush_all();
			end else begin
				// a packet followed by a flush must find an empty pipeline
				if (i + 1 < cmd_kind.size() && cmd_kind[i+1] == KIND_FLUSH)
					drain_pipeline();
				else
					idle_gaps();
				send_packet(i);
			end
		end
		drain_pipeline();

		check_value("credit_o sum", pushed - discarded, credit_sum);
		if (exp_rd.size() != 0) begin
			errors++;
			$display("%0d expected retirements never appeared", exp_rd.size());
		end
		assert_fails = dut.u_props.fail_count;
		$display("Done: %0d errors, %0d assertion failures, %0d retirements checked, %0d entries pushed, %0d credits",
			errors, assert_fails, n_checked, pushed, credit_sum);
		if (errors == 0 && assert_fails == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

/* tb/core_backend_testdata.txt */
# P offset count lane0 lane1 lane2 lane3 (hex), F flushes buffer and pipeline
# E rd value (hex), expected retirements in program order
P 0 4 6101 5205 5327 1413
E 1 1000
E 2 0005
E 3 000c
E 4 100c
P 2 3 4761 5f0f 2542 3654
E 5 1007
E 6 1004
E 7 0004
P 1 2 5f0f 577f 2807 5f0f
E 7 0013
E 8 ffed
P 3 4 4988 5991 6a0a 0123
E 9 0000
E 9 0001
E a a000
P 0 3 5b03 5b09 1cbb 5f0f
E b 0003
E b 0009
E c 0012
P 2 4 1fed 411f 2dc9 3ea8
E d 0011
E e a000
E f a011
E 1 b011
P 1 4 540f 510f 520f 530f
F
P 0 2 121c 232f 0000 0000
E 2 b023
E 3 1012
P 3 1 0000 0000 0000 5432
E 4 1014
